// File: list.f
rtl/stb_pkg.sv
rtl/wb_pkg.sv
rtl/stb_rd_if.sv
rtl/stb_thread_buf.sv
rtl/stb_ovfl_chk.sv
rtl/stb_drain_wb.sv
rtl/stb_top.sv
bench/stb_checker.sv
bench/stb_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the store buffer testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f list.f --top-module stb_tb -Mdir obj_dir -o stb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/stb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

grep -qx "=== PASS ===" sim.log
if [ $? -ne 0 ]; then
   echo "Pass line not found in sim.log"
   exit 1
fi
exit 0

// File: bench/stb_tb.sv
// *************************************************************************
// Store buffer testbench with random stores, a Wishbone slave and a report
// *************************************************************************

`timescale 1ns/1ps

module stb_tb;

   localparam int DEPTH        = stb_pkg::STB_DEPTH;
   localparam int NT           = stb_pkg::NUM_THREADS;
   localparam int ORDER_CYCLES = 400;
   localparam int OVFL_CYCLES  = 200;
   localparam int RESET_CYCLES = 400;
   localparam int DRAIN_CYCLES = 200;
   // Four times the stimulus length with reset included
   localparam int WATCHDOG_CYCLES =
      4 * (5 + ORDER_CYCLES + OVFL_CYCLES + RESET_CYCLES + DRAIN_CYCLES);

   logic                clk;
   logic                rst_l;
   logic                st_valid;
   stb_pkg::stb_tid_t   st_tid;
   stb_pkg::stb_addr_t  st_addr;
   stb_pkg::stb_data_t  st_data;
   logic [NT-1:0]       stb_reset;
   stb_pkg::stb_cnt_t   stb_cnt [NT];
   logic [NT-1:0]       stb_full;
   logic [NT-1:0]       stb_ovfl;
   logic                wb_cyc;
   logic                wb_stb;
   logic                wb_we;
   wb_pkg::wb_adr_t     wb_adr;
   wb_pkg::wb_dat_t     wb_dat_o;
   wb_pkg::wb_sel_t     wb_sel;
   logic                wb_ack = 1'b0;

   // Separate generator states keep stimulus and ack delays independent
   logic [31:0]         stim_seed = 32'h1739;
   logic [31:0]         ack_seed = 32'h1739;
   int                  ack_wait = 0;
   int                  serial = 0;
   int                  chk_errors;
   int                  chk_acked;

   stb_top #(
      .depth (DEPTH)
   ) dut_i (
      .clk       (clk),
      .rst_l     (rst_l),
      .st_valid  (st_valid),
      .st_tid    (st_tid),
      .st_addr   (st_addr),
      .st_data   (st_data),
      .stb_reset (stb_reset),
      .stb_cnt   (stb_cnt),
      .stb_full  (stb_full),
      .stb_ovfl  (stb_ovfl),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_o  (wb_dat_o),
      .wb_sel    (wb_sel),
      .wb_ack    (wb_ack)
   );

   stb_checker #(
      .depth (DEPTH)
   ) chk_i (
      .clk       (clk),
      .rst_l     (rst_l),
      .st_valid  (st_valid),
      .st_tid    (st_tid),
      .st_addr   (st_addr),
      .st_data   (st_data),
      .stb_reset (stb_reset),
      .stb_cnt   (stb_cnt),
      .stb_full  (stb_full),
      .stb_ovfl  (stb_ovfl),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_o  (wb_dat_o),
      .wb_sel    (wb_sel),
      .wb_ack    (wb_ack),
      .errors    (chk_errors),
      .acked     (chk_acked)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic buffers_empty();
      logic empty;
      empty = !wb_cyc;
      for (int t = 0; t < NT; t++)
         if (stb_cnt[t] != '0)
            empty = 1'b0;
      return empty;
   endfunction

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Wishbone slave acks for one cycle after 0 to 3 counted wait cycles
   always @(posedge clk)
   begin
      if (rst_l)
         wb_ack <= 1'b0;
      else if (wb_ack)
         wb_ack <= 1'b0;
      else if (wb_stb)
      begin
         if (ack_wait == 0)
            wb_ack <= 1'b1;
         else
            ack_wait <= ack_wait - 1;
      end
      else
      begin
         ack_seed = lcg_step(ack_seed);
         ack_wait <= int'(ack_seed[31:30]);
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the buffers never drained",
         WATCHDOG_CYCLES);
      $display("=== FAIL ===");
      $finish;
   end

   // ************************************************************************
   // Stimulus phases
   // ************************************************************************

   // Mode 0 respects the count while mode 1 hammers one thread and mode 2 adds resets
   task automatic drive_phase(input string name, input int cycles, input int mode);
      logic [31:0]       r;
      stb_pkg::stb_tid_t tid;
      stb_pkg::stb_tid_t hot;
      logic              go;
      logic [NT-1:0]     rmask;
      int                err0;
      int                sent0;
      err0 = chk_errors;
      sent0 = serial;
      stim_seed = lcg_step(stim_seed);
      hot = stim_seed[31:30];
      for (int c = 0; c < cycles; c++)
      begin
         @(posedge clk);
         stim_seed = lcg_step(stim_seed);
         r = stim_seed;
         tid = r[31:30];
         if ((mode == 1) && (r[29:28] != 2'b00))
            tid = hot;
         // Stay a slot below full because one store may still be in flight
         go = r[27] && (stb_cnt[tid] < DEPTH - 1);
         if ((mode == 1) && (tid == hot))
            go = 1'b1;
         if ((mode == 2) && r[27] && r[16])
            go = 1'b1;
         rmask = '0;
         if (mode == 2)
         begin
            if (r[26:23] == 4'd0)
               rmask[r[22:21]] = 1'b1;
            // Sometimes hit the thread whose write is on the bus
            if (wb_cyc && (r[20:18] == 3'd0))
               rmask[wb_adr[31:30]] = 1'b1;
         end
         st_valid  <= go;
         st_tid    <= tid;
         st_addr   <= {tid, r[29:2], 2'b00};
         st_data   <= serial;
         stb_reset <= rmask;
         if (go)
            serial++;
      end
      $display("phase %s: %0d cycles, %0d stores, %0d bus writes so far, %0d errors",
         name, cycles, serial - sent0, chk_acked, chk_errors - err0);
   endtask

   // Release overflowed threads and wait for every buffer to empty
   task automatic drain_out();
      logic [NT-1:0] rmask;
      int            err0;
      err0 = chk_errors;
      @(posedge clk);
      st_valid  <= 1'b0;
      stb_reset <= '0;
      // Counts are read only after the last store has landed
      @(posedge clk);
      rmask = stb_ovfl;
      for (int t = 0; t < NT; t++)
         if (stb_cnt[t] > DEPTH)
            rmask[t] = 1'b1;
      stb_reset <= rmask;
      @(posedge clk);
      stb_reset <= '0;
      do
         @(posedge clk);
      while (!buffers_empty());
      $display("phase drain: %0d bus writes so far, %0d errors",
         chk_acked, chk_errors - err0);
   endtask

   initial
   begin
      rst_l     = 1'b1;
      st_valid  = 1'b0;
      st_tid    = '0;
      st_addr   = '0;
      st_data   = '0;
      stb_reset = '0;
      repeat (5) @(posedge clk);
      rst_l <= 1'b0;
      drive_phase("order", ORDER_CYCLES, 0);
      drive_phase("overflow", OVFL_CYCLES, 1);
      drive_phase("reset", RESET_CYCLES, 2);
      drain_out();
      repeat (2) @(posedge clk);
      $display("summary: %0d stores, %0d bus writes checked, %0d errors",
         serial, chk_acked, chk_errors);
      if (chk_errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: bench/stb_checker.sv
// *************************************************************************
// Store buffer checker with a reference model of buffers, flags and drain
// *************************************************************************

`timescale 1ns/1ps

module stb_checker #(
   parameter int depth = stb_pkg::STB_DEPTH
) (
   input  logic                            clk,
   input  logic                            rst_l,
   input  logic                            st_valid,
   input  stb_pkg::stb_tid_t               st_tid,
   input  stb_pkg::stb_addr_t              st_addr,
   input  stb_pkg::stb_data_t              st_data,
   input  logic [stb_pkg::NUM_THREADS-1:0] stb_reset,
   input  stb_pkg::stb_cnt_t               stb_cnt [stb_pkg::NUM_THREADS],
   input  logic [stb_pkg::NUM_THREADS-1:0] stb_full,
   input  logic [stb_pkg::NUM_THREADS-1:0] stb_ovfl,
   input  logic                            wb_cyc,
   input  logic                            wb_stb,
   input  logic                            wb_we,
   input  wb_pkg::wb_adr_t                 wb_adr,
   input  wb_pkg::wb_dat_t                 wb_dat_o,
   input  wb_pkg::wb_sel_t                 wb_sel,
   input  logic                            wb_ack,
   output int                              errors,
   output int                              acked
);

   localparam int NT = stb_pkg::NUM_THREADS;

   // Model queues hold the address and data of stored entries with the oldest first
   logic [63:0]   mq [NT][$];
   int            m_cnt [NT];
   logic [NT-1:0] m_ovfl;
   logic [NT-1:0] m_rdly;
   int            err_cnt = 0;
   int            ack_cnt = 0;

   // Drain tracking covers the grant, the open request and a head lost mid-request
   int            last_gnt;
   int            gnt;
   int            pend_tid;
   logic          pend;
   logic          in_req;
   logic          m_lost;
   logic [63:0]   pend_word;
   wb_pkg::wb_adr_t hold_adr;
   wb_pkg::wb_dat_t hold_dat;

   assign errors = err_cnt;
   assign acked  = ack_cnt;

   task automatic report_err(input string msg);
      $display("ERR %0t: %s", $time, msg);
      err_cnt++;
   endtask

   // ************************************************************************
   // Each edge compares the settled values and then advances the model
   // ************************************************************************

   always @(posedge clk)
   begin : model_step
      logic [NT-1:0] hv;
      logic [NT-1:0] elig;
      logic          pop_now;
      logic          wr;
      logic          pp;
      logic          found;
      int            idx;
      int            pick;
      if (rst_l)
      begin
         for (int t = 0; t < NT; t++)
         begin
            mq[t].delete();
            m_cnt[t] = 0;
         end
         m_ovfl   = '0;
         m_rdly   = '0;
         last_gnt = NT - 1;
         pend     = 1'b0;
         in_req   = 1'b0;
         m_lost   = 1'b0;
      end
      else
      begin
         for (int t = 0; t < NT; t++)
         begin
            if (int'(stb_cnt[t]) != m_cnt[t])
               report_err($sformatf("count of thread %0d is %0d, model %0d",
                  t, stb_cnt[t], m_cnt[t]));
            if (stb_full[t] != (m_cnt[t] >= depth))
               report_err($sformatf("full flag of thread %0d is %0b", t, stb_full[t]));
            if (stb_ovfl[t] != m_ovfl[t])
               report_err($sformatf("overflow flag of thread %0d is %0b, model %0b",
                  t, stb_ovfl[t], m_ovfl[t]));
            // A head exists only while every counted entry is really stored
            hv[t]   = (m_cnt[t] >= 1) && (m_cnt[t] <= depth);
            elig[t] = hv[t] && !m_ovfl[t];
         end
         pop_now = 1'b0;
         if (pend)
         begin
            // A grant made at the previous edge means the request is up now
            if (!(wb_cyc && wb_stb && wb_we))
               report_err($sformatf("no bus write after grant to thread %0d", pend_tid));
            else if (int'(wb_adr[31:30]) != pend_tid)
               report_err($sformatf("grant went to thread %0d, next eligible is %0d",
                  wb_adr[31:30], pend_tid));
            else if ({wb_adr, wb_dat_o} != pend_word)
               report_err($sformatf("write %h/%h is not the oldest store %h",
                  wb_adr, wb_dat_o, pend_word));
            if (wb_sel != wb_pkg::WB_SEL_WORD)
               report_err($sformatf("byte select %b is not a full word", wb_sel));
            gnt      = pend_tid;
            hold_adr = wb_adr;
            hold_dat = wb_dat_o;
            in_req   = 1'b1;
            m_lost   = 1'b0;
            pend     = 1'b0;
         end
         else if (!in_req)
         begin
            if (wb_cyc || wb_stb || wb_we)
               report_err("bus active without a grant");
            found = 1'b0;
            pick  = 0;
            for (int i = 1; i <= NT; i++)
            begin
               idx = (last_gnt + i) % NT;
               if (!found && elig[idx])
               begin
                  found = 1'b1;
                  pick  = idx;
               end
            end
            if (found)
            begin
               pend      = 1'b1;
               pend_tid  = pick;
               pend_word = mq[pick][0];
               last_gnt  = pick;
            end
         end
         if (in_req)
         begin
            if (!wb_cyc || !wb_stb)
               report_err("request dropped before ack");
            if ((wb_adr != hold_adr) || (wb_dat_o != hold_dat))
               report_err("address or data changed while waiting for ack");
            // A head that vanished mid-request is not popped on ack
            pop_now = wb_ack && !m_lost && hv[gnt];
            if (!hv[gnt])
               m_lost = 1'b1;
            if (wb_ack)
            begin
               in_req = 1'b0;
               ack_cnt++;
            end
         end
         for (int t = 0; t < NT; t++)
         begin
            wr = st_valid && (int'(st_tid) == t);
            pp = pop_now && (gnt == t);
            if (stb_reset[t])
            begin
               mq[t].delete();
               m_cnt[t]  = 0;
               m_ovfl[t] = 1'b0;
            end
            else
            begin
               // Flag uses the count before this edge and is masked right after a reset
               if ((m_cnt[t] > depth) && !m_rdly[t])
                  m_ovfl[t] = 1'b1;
               if (pp)
                  void'(mq[t].pop_front());
               if (wr && ((m_cnt[t] < depth) || pp))
                  mq[t].push_back({st_addr, st_data});
               if (wr && !pp && (m_cnt[t] != 15))
                  m_cnt[t]++;
               else if (!wr && pp)
                  m_cnt[t]--;
            end
            m_rdly[t] = stb_reset[t];
         end
      end
   end

endmodule

// File: rtl/stb_top.sv
// *************************************************************************
// Store buffer top: thread buffers, overflow checker and Wishbone drain
// *************************************************************************

`timescale 1ns/1ps

module stb_top #(
   parameter int depth = stb_pkg::STB_DEPTH
) (
   input  logic                            clk,
   input  logic                            rst_l,
   // Store write port, one store per cycle from any thread
   input  logic                            st_valid,
   input  stb_pkg::stb_tid_t               st_tid,
   input  stb_pkg::stb_addr_t              st_addr,
   input  stb_pkg::stb_data_t              st_data,
   input  logic [stb_pkg::NUM_THREADS-1:0] stb_reset,
   // Status per thread
   output stb_pkg::stb_cnt_t               stb_cnt [stb_pkg::NUM_THREADS],
   output logic [stb_pkg::NUM_THREADS-1:0] stb_full,
   output logic [stb_pkg::NUM_THREADS-1:0] stb_ovfl,
   // Wishbone classic master
   output logic                            wb_cyc,
   output logic                            wb_stb,
   output logic                            wb_we,
   output wb_pkg::wb_adr_t                 wb_adr,
   output wb_pkg::wb_dat_t                 wb_dat_o,
   output wb_pkg::wb_sel_t                 wb_sel,
   input  logic                            wb_ack
);

   // Heads and pops between the buffers and the drain
   stb_rd_if rd_if ();

   stb_thread_buf #(
      .depth (depth)
   ) buf_i (
      .clk       (clk),
      .rst_l     (rst_l),
      .st_valid  (st_valid),
      .st_tid    (st_tid),
      .st_addr   (st_addr),
      .st_data   (st_data),
      .stb_reset (stb_reset),
      .cnt       (stb_cnt),
      .full      (stb_full),
      .rd        (rd_if.buf_mp)
   );

   // Watches the counts the buffers publish on the status port
   stb_ovfl_chk #(
      .depth (depth)
   ) chk_i (
      .clk       (clk),
      .rst_l     (rst_l),
      .cnt       (stb_cnt),
      .stb_reset (stb_reset),
      .ovfl      (stb_ovfl)
   );

   // Flags from the checker keep overflowed threads off the bus
   stb_drain_wb drain_i (
      .clk      (clk),
      .rst_l    (rst_l),
      .ovfl     (stb_ovfl),
      .wb_ack   (wb_ack),
      .rd       (rd_if.drain_mp),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_o (wb_dat_o),
      .wb_sel   (wb_sel)
   );

endmodule

// File: rtl/stb_drain_wb.sv
// *************************************************************************
// Drain engine: round-robin thread pick and Wishbone classic write master
// *************************************************************************

`timescale 1ns/1ps

module stb_drain_wb (
   input  logic                            clk,
   input  logic                            rst_l,
   input  logic [stb_pkg::NUM_THREADS-1:0] ovfl,
   input  logic                            wb_ack,
   stb_rd_if.drain_mp                      rd,
   output logic                            wb_cyc,
   output logic                            wb_stb,
   output logic                            wb_we,
   output wb_pkg::wb_adr_t                 wb_adr,
   output wb_pkg::wb_dat_t                 wb_dat_o,
   output wb_pkg::wb_sel_t                 wb_sel
);

   localparam int NT = stb_pkg::NUM_THREADS;

   wb_pkg::drain_state_t state;
   // Last granted thread, which is also the owner of the request in flight
   stb_pkg::stb_tid_t    gnt_tid;
   // Set when the granted head vanished by reset or overflow mid-request
   logic                 lost;

   logic [NT-1:0]        eligible;
   logic                 pick_ok;
   stb_pkg::stb_tid_t    pick_tid;

   // Overflowed threads are held back until their buffer reset
   assign eligible = rd.head_valid & ~ovfl;

   // Search starts at the thread after the last grant
   always_comb
   begin : rr_pick
      int idx;
      pick_ok  = 1'b0;
      pick_tid = '0;
      for (int i = 1; i <= NT; i++)
      begin
         idx = (int'(gnt_tid) + i) % NT;
         if (!pick_ok && eligible[idx])
         begin
            pick_ok  = 1'b1;
            pick_tid = stb_pkg::stb_tid_t'(idx);
         end
      end
   end

   // The write still completes if its head is gone, but nothing is popped
   assign rd.pop     = (state == wb_pkg::BUS) && wb_ack && !lost && rd.head_valid[gnt_tid];
   assign rd.pop_tid = gnt_tid;

   // ************************************************************************
   // Control state
   // ************************************************************************

   always_ff @(posedge clk)
   begin
      if (rst_l)
      begin
         state   <= wb_pkg::IDLE;
         wb_cyc  <= 1'b0;
         wb_stb  <= 1'b0;
         wb_we   <= 1'b0;
         lost    <= 1'b0;
         // Thread 0 is the first to be served
         gnt_tid <= stb_pkg::stb_tid_t'(NT - 1);
      end
      else
      begin
         case (state)
            wb_pkg::IDLE:
            begin
               if (pick_ok)
               begin
                  state   <= wb_pkg::BUS;
                  wb_cyc  <= 1'b1;
                  wb_stb  <= 1'b1;
                  wb_we   <= 1'b1;
                  lost    <= 1'b0;
                  gnt_tid <= pick_tid;
               end
            end
            wb_pkg::BUS:
            begin
               if (!rd.head_valid[gnt_tid])
                  lost <= 1'b1;
               // The request drops in the cycle after ack is sampled
               if (wb_ack)
               begin
                  state  <= wb_pkg::IDLE;
                  wb_cyc <= 1'b0;
                  wb_stb <= 1'b0;
                  wb_we  <= 1'b0;
               end
            end
            default: state <= wb_pkg::IDLE;
         endcase
      end
   end

   // Bus payload is captured at grant and held for the whole request
   always_ff @(posedge clk)
   begin
      if ((state == wb_pkg::IDLE) && pick_ok)
      begin
         wb_adr   <= wb_pkg::wb_adr_t'(rd.head_addr[pick_tid]);
         wb_dat_o <= wb_pkg::wb_dat_t'(rd.head_data[pick_tid]);
         wb_sel   <= wb_pkg::WB_SEL_WORD;
      end
   end

   // A waiting request keeps strobe, address and data until the slave acks
   bus_hold: assert property (@(posedge clk) disable iff (rst_l)
      (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat_o)));

endmodule

// File: rtl/stb_ovfl_chk.sv
// *************************************************************************
// Overflow checker: sticky per-thread flag when a count passes depth
// *************************************************************************

`timescale 1ns/1ps

module stb_ovfl_chk #(
   parameter int depth = stb_pkg::STB_DEPTH
) (
   input  logic                            clk,
   input  logic                            rst_l,
   input  stb_pkg::stb_cnt_t               cnt [stb_pkg::NUM_THREADS],
   input  logic [stb_pkg::NUM_THREADS-1:0] stb_reset,
   output logic [stb_pkg::NUM_THREADS-1:0] ovfl
);

   localparam int NT = stb_pkg::NUM_THREADS;

   // Buffer reset delayed by one edge masks the first cycle after it
   logic [NT-1:0] rst_dly;

   always_ff @(posedge clk)
   begin
      if (rst_l)
      begin
         rst_dly <= '0;
         ovfl    <= '0;
      end
      else
      begin
         rst_dly <= stb_reset;
         for (int t = 0; t < NT; t++)
         begin
            // The thread's reset wins over a new detection
            if (stb_reset[t])
               ovfl[t] <= 1'b0;
            else if ((cnt[t] > depth) && !rst_dly[t])
               ovfl[t] <= 1'b1;
         end
      end
   end

   // One edge after a buffer reset the flag must still read clear
   for (genvar t = 0; t < NT; t++)
   begin : g_mask_chk
      reset_mask: assert property (@(posedge clk) disable iff (rst_l)
         $past(stb_reset[t]) |=> !ovfl[t]);
   end

endmodule

// File: rtl/stb_thread_buf.sv
// *************************************************************************
// Per-thread store buffers: circular address/data storage with counts
// *************************************************************************

`timescale 1ns/1ps

module stb_thread_buf #(
   parameter int depth = stb_pkg::STB_DEPTH
) (
   input  logic                            clk,
   input  logic                            rst_l,
   input  logic                            st_valid,
   input  stb_pkg::stb_tid_t               st_tid,
   input  stb_pkg::stb_addr_t              st_addr,
   input  stb_pkg::stb_data_t              st_data,
   input  logic [stb_pkg::NUM_THREADS-1:0] stb_reset,
   output stb_pkg::stb_cnt_t               cnt [stb_pkg::NUM_THREADS],
   output logic [stb_pkg::NUM_THREADS-1:0] full,
   stb_rd_if.buf_mp                        rd
);

   localparam int NT    = stb_pkg::NUM_THREADS;
   localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;

   // Storage has no reset, only the pointers and counts do
   stb_pkg::stb_addr_t addr_mem [NT][depth];
   stb_pkg::stb_data_t data_mem [NT][depth];
   logic [PTR_W-1:0]   wr_ptr [NT];
   logic [PTR_W-1:0]   rd_ptr [NT];

   logic [NT-1:0]      wr_req;
   logic [NT-1:0]      pop_req;
   logic [NT-1:0]      wr_store;
   stb_pkg::stb_cnt_t  cnt_nxt [NT];

   // Pointers wrap at depth, which need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(depth - 1))
         return '0;
      return p + 1'b1;
   endfunction

   always_comb
   begin
      for (int t = 0; t < NT; t++)
      begin
         wr_req[t]  = st_valid && (st_tid == stb_pkg::stb_tid_t'(t));
         pop_req[t] = rd.pop && (rd.pop_tid == stb_pkg::stb_tid_t'(t));
         // A write lands only if a slot is free after this edge's pop
         // A buffer reset on the same edge discards it
         wr_store[t] = wr_req[t] && !stb_reset[t] && ((cnt[t] < depth) || pop_req[t]);
         // Dropped writes still count, so the count runs past depth up to 15
         cnt_nxt[t] = cnt[t];
         if (wr_req[t] && !pop_req[t] && (cnt[t] != '1))
            cnt_nxt[t] = cnt[t] + 1'b1;
         else if (!wr_req[t] && pop_req[t])
            cnt_nxt[t] = cnt[t] - 1'b1;
         // A head exists only while the count matches real storage
         rd.head_valid[t] = (cnt[t] != '0) && (cnt[t] <= depth);
         rd.head_addr[t]  = addr_mem[t][rd_ptr[t]];
         rd.head_data[t]  = data_mem[t][rd_ptr[t]];
         // Full is advisory, the store port has no back-pressure
         full[t] = (cnt[t] >= depth);
      end
   end

   // Counts and pointers, cleared by global reset or the thread's own reset
   always_ff @(posedge clk)
   begin
      for (int t = 0; t < NT; t++)
      begin
         if (rst_l || stb_reset[t])
         begin
            cnt[t]    <= '0;
            wr_ptr[t] <= '0;
            rd_ptr[t] <= '0;
         end
         else
         begin
            cnt[t] <= cnt_nxt[t];
            if (wr_store[t])
               wr_ptr[t] <= ptr_inc(wr_ptr[t]);
            if (pop_req[t])
               rd_ptr[t] <= ptr_inc(rd_ptr[t]);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      for (int t = 0; t < NT; t++)
      begin
         if (wr_store[t])
         begin
            addr_mem[t][wr_ptr[t]] <= st_addr;
            data_mem[t][wr_ptr[t]] <= st_data;
         end
      end
   end

   // The drain must never retire an entry from an empty thread
   pop_not_empty: assert property (@(posedge clk) disable iff (rst_l)
      rd.pop |-> (cnt[rd.pop_tid] != '0));

endmodule

// File: rtl/stb_rd_if.sv
// *************************************************************************
// Read side of the store buffers: per-thread heads out, pop requests in
// *************************************************************************

`timescale 1ns/1ps

interface stb_rd_if;

   // Head of each thread, valid while the count is between one and depth
   logic [stb_pkg::NUM_THREADS-1:0] head_valid;
   stb_pkg::stb_addr_t              head_addr [stb_pkg::NUM_THREADS];
   stb_pkg::stb_data_t              head_data [stb_pkg::NUM_THREADS];

   // Pop removes the head of pop_tid at the clock edge
   logic                            pop;
   stb_pkg::stb_tid_t               pop_tid;

   // The buffers publish their heads and accept pops
   modport buf_mp (
      output head_valid,
      output head_addr,
      output head_data,
      input  pop,
      input  pop_tid
   );

   // The drain engine reads heads and retires the entry it has sent
   modport drain_mp (
      input  head_valid,
      input  head_addr,
      input  head_data,
      output pop,
      output pop_tid
   );

endinterface

// File: rtl/wb_pkg.sv
// *************************************************************************
// Wishbone package: bus widths, byte select and drain engine states
// *************************************************************************

package wb_pkg;

   localparam int WB_ADR_W = 32;
   localparam int WB_DAT_W = 32;
   // One select bit per byte lane
   localparam int WB_SEL_W = WB_DAT_W / 8;

   typedef logic [WB_ADR_W-1:0] wb_adr_t;
   typedef logic [WB_DAT_W-1:0] wb_dat_t;
   typedef logic [WB_SEL_W-1:0] wb_sel_t;

   // Every store is a full word, so all lanes are enabled
   localparam wb_sel_t WB_SEL_WORD = '1;

   // IDLE waits for an eligible head, BUS holds a single classic write
   typedef enum logic {IDLE, BUS} drain_state_t;

endpackage

// File: rtl/stb_pkg.sv
// *************************************************************************
// Store buffer package: thread count, depth and the widths that travel
// between the per-thread buffers, the overflow checker and the drain
// *************************************************************************

package stb_pkg;

   // Number of hardware threads sharing the load/store unit
   localparam int NUM_THREADS = 4;

   // Default number of entries per thread, overridden through the top level
   localparam int STB_DEPTH = 8;

   // Thread index wide enough for every thread
   localparam int STB_TID_W = $clog2(NUM_THREADS);

   // Count width leaves room above the depth, so an overflow stays visible
   localparam int STB_CNT_W = 4;

   typedef logic [STB_TID_W-1:0] stb_tid_t;

   // Entry count, saturating at its all-ones value of 15
   typedef logic [STB_CNT_W-1:0] stb_cnt_t;

   // Store address and store data are full words
   typedef logic [31:0] stb_addr_t;
   typedef logic [31:0] stb_data_t;

endpackage
